/* src.f */
+incdir+bench
design/tetris_pkg.sv
design/lock_writer.sv
design/playfield_row.sv
design/line_clear_counter.sv
design/time_digit.sv
design/sprint_timer.sv
design/tetris_board_top.sv
bench/tb_board.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the board testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -j 0 --top-module tb_board -f src.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_board > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -qx "TEST PASS" "$log"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see $log"
exit 1

/* bench/board_model.svh */
`ifndef BOARD_MODEL_SVH
`define BOARD_MODEL_SVH

// write the piece, drop full rows, pack the rest to the bottom in order
function automatic int apply_lock(
    input tetris_pkg::row_idx_t   rows [tetris_pkg::PIECE_CELLS],
    input tetris_pkg::col_idx_t   cols [tetris_pkg::PIECE_CELLS],
    input tetris_pkg::tile_type_t kind
);
    tetris_pkg::tile_type_t next_board [tetris_pkg::PLAYFIELD_ROWS]
                                       [tetris_pkg::PLAYFIELD_COLS];
    int removed;
    int dst;
    bit full;
    bit empty;
    for (int k = 0; k < tetris_pkg::PIECE_CELLS; k++) begin
        model_board[rows[k]][cols[k]] = kind;
    end
    next_board = '{default: tetris_pkg::BLANK};
    removed = 0;
    dst = tetris_pkg::PLAYFIELD_ROWS - 1;
    for (int r = tetris_pkg::PLAYFIELD_ROWS - 1; r >= 0; r--) begin
        full  = 1'b1;
        empty = 1'b1;
        for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
            if (model_board[r][c] == tetris_pkg::BLANK) begin
                full = 1'b0;
            end else begin
                empty = 1'b0;
            end
        end
        if (full) begin
            removed++;
        end else if (!empty) begin
            next_board[dst] = model_board[r];
            dst--;
        end
    end
    model_board = next_board;
    return removed;
endfunction

// one timer stage from the total count of running cycles
function automatic tetris_pkg::digit_t expected_digit(input int running, input int idx);
    int value;
    value = running / ticks_per_ms;
    for (int i = 0; i < idx; i++) begin
        value = value / (int'(tetris_pkg::DIGIT_LIMITS[i]) + 1);
    end
    return tetris_pkg::digit_t'(value % (int'(tetris_pkg::DIGIT_LIMITS[idx]) + 1));
endfunction

`endif

/* bench/tb_board.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_board;

    localparam int ticks_per_ms = 3;
    localparam int rows_n       = tetris_pkg::PLAYFIELD_ROWS;
    localparam int cols_n       = tetris_pkg::PLAYFIELD_COLS;
    localparam int settle_limit = rows_n + 2;
    localparam int first_run    = 7500;
    localparam int idle_time    = 200;
    localparam int second_run   = 302;
    localparam int max_locks    = 220;
    // timer phases plus a few cycles per lock and half again as margin
    localparam int timeout_cycles =
        (first_run + idle_time + second_run + max_locks * 5) * 3 / 2;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     game_start;
    logic                     lock;
    tetris_pkg::row_idx_t     lock_rows [tetris_pkg::PIECE_CELLS];
    tetris_pkg::col_idx_t     lock_cols [tetris_pkg::PIECE_CELLS];
    tetris_pkg::tile_type_t   lock_type;
    logic                     timer_running;
    tetris_pkg::tile_type_t   board [rows_n][cols_n];
    tetris_pkg::lines_count_t lines_cleared;
    logic                     board_settled;
    tetris_pkg::digit_t       time_digits [tetris_pkg::TIME_DIGITS];

    tetris_pkg::tile_type_t model_board [rows_n][cols_n];
    tetris_pkg::row_idx_t   piece_rows [tetris_pkg::PIECE_CELLS];
    tetris_pkg::col_idx_t   piece_cols [tetris_pkg::PIECE_CELLS];
    int exp_lines   = 0;
    int run_cycles  = 0;
    int seed        = 32'h8e8f;
    int req_count   = 0;
    int ack_count   = 0;
    int cycle_count = 0;

    `include "board_model.svh"

    tetris_board_top #(
        .ticks_per_ms (ticks_per_ms)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .game_start    (game_start),
        .lock          (lock),
        .lock_rows     (lock_rows),
        .lock_cols     (lock_cols),
        .lock_type     (lock_type),
        .timer_running (timer_running),
        .board         (board),
        .lines_cleared (lines_cleared),
        .board_settled (board_settled),
        .time_digits   (time_digits)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("run did not finish within %0d clock cycles", timeout_cycles);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_board(input int r, input int c,
                               input tetris_pkg::tile_type_t expected,
                               input tetris_pkg::tile_type_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: board[%0d][%0d] expected %0d, got %0d",
                     $time, r, c, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "board mismatch");
        end
    endtask

    task automatic check_lines(input tetris_pkg::lines_count_t expected,
                               input tetris_pkg::lines_count_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: lines_cleared expected %0d, got %0d",
                     $time, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "line count mismatch");
        end
    endtask

    task automatic check_time(input int idx, input tetris_pkg::digit_t expected,
                              input tetris_pkg::digit_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: time_digits[%0d] expected %0d, got %0d",
                     $time, idx, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "timer mismatch");
        end
    endtask

    // compares on the falling edge once the board has settled
    initial begin : compare_results
        int waited;
        forever begin
            wait (req_count != ack_count);
            @(negedge clk);
            waited = 0;
            while (!board_settled) begin
                if (waited == settle_limit) begin
                    $display("board_settled stayed low for %0d cycles", settle_limit);
                    $display("TEST FAIL");
                    $fatal(1, "board did not settle");
                end
                waited++;
                @(negedge clk);
            end
            for (int r = 0; r < rows_n; r++) begin
                for (int c = 0; c < cols_n; c++) begin
                    check_board(r, c, model_board[r][c], board[r][c]);
                end
            end
            check_lines(tetris_pkg::lines_count_t'(exp_lines), lines_cleared);
            for (int d = 0; d < tetris_pkg::TIME_DIGITS; d++) begin
                check_time(d, expected_digit(run_cycles, d), time_digits[d]);
            end
            ack_count = ack_count + 1;
        end
    end

    task automatic request_check();
        req_count = req_count + 1;
        wait (ack_count == req_count);
    endtask

    task automatic clear_model();
        model_board = '{default: tetris_pkg::BLANK};
        exp_lines   = 0;
        run_cycles  = 0;
    endtask

    function automatic tetris_pkg::tile_type_t random_kind();
        return tetris_pkg::tile_type_t'(3'(1 + $unsigned($random(seed)) % 7));
    endfunction

    function automatic int count_tiles(input int r);
        int n;
        n = 0;
        for (int c = 0; c < cols_n; c++) begin
            if (model_board[r][c] != tetris_pkg::BLANK) begin
                n++;
            end
        end
        return n;
    endfunction

    // holes counts the bottom rows whose single gap gets filled
    // max_fill caps the tiles in any other row
    task automatic pick_piece(input int holes, input int max_fill);
        bit taken [rows_n][cols_n];
        int count;
        int r;
        int c;
        int used;
        for (int i = 0; i < rows_n; i++) begin
            for (int j = 0; j < cols_n; j++) begin
                taken[i][j] = (model_board[i][j] != tetris_pkg::BLANK);
            end
        end
        count = 0;
        c = 0;
        for (int h = 0; h < holes; h++) begin
            r = rows_n - 1 - h;
            for (int j = 0; j < cols_n; j++) begin
                if (!taken[r][j]) begin
                    c = j;
                end
            end
            taken[r][c] = 1'b1;
            piece_rows[count] = tetris_pkg::row_idx_t'(r);
            piece_cols[count] = tetris_pkg::col_idx_t'(c);
            count++;
        end
        // the rest lands low on the stack at random columns
        r = rows_n - 1;
        while (count < tetris_pkg::PIECE_CELLS) begin
            used = 0;
            for (int j = 0; j < cols_n; j++) begin
                used += int'(taken[r][j]);
            end
            if (used >= max_fill) begin
                r--;
            end else begin
                c = $unsigned($random(seed)) % cols_n;
                if (!taken[r][c]) begin
                    taken[r][c] = 1'b1;
                    piece_rows[count] = tetris_pkg::row_idx_t'(r);
                    piece_cols[count] = tetris_pkg::col_idx_t'(c);
                    count++;
                end
            end
        end
    endtask

    task automatic place_piece();
        tetris_pkg::tile_type_t kind;
        kind = random_kind();
        @(posedge clk);
        lock      <= 1'b1;
        lock_type <= kind;
        for (int k = 0; k < tetris_pkg::PIECE_CELLS; k++) begin
            lock_rows[k] <= piece_rows[k];
            lock_cols[k] <= piece_cols[k];
        end
        @(posedge clk);
        lock <= 1'b0;
        exp_lines = exp_lines + apply_lock(piece_rows, piece_cols, kind);
        request_check();
    endtask

    // leave one gap in each of the bottom n rows, then fill them all at once
    task automatic clear_rows(input int n);
        while (count_tiles(rows_n - n) < cols_n - 1) begin
            pick_piece(0, cols_n - 1);
            place_piece();
        end
        pick_piece(n, cols_n - 1);
        place_piece();
    endtask

    task automatic run_timer(input int cycles);
        @(posedge clk);
        timer_running <= 1'b1;
        repeat (cycles) @(posedge clk);
        timer_running <= 1'b0;
        run_cycles = run_cycles + cycles;
        request_check();
    endtask

    initial begin
        reset         = 1'b1;
        game_start    = 1'b0;
        lock          = 1'b0;
        lock_type     = tetris_pkg::BLANK;
        timer_running = 1'b0;
        lock_rows     = '{default: '0};
        lock_cols     = '{default: '0};
        clear_model();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        request_check();

        // partial rows only
        repeat (9) begin
            pick_piece(0, cols_n - 1);
            place_piece();
        end

        clear_rows(1);
        clear_rows(2);
        clear_rows(4);

        // count goes past 63 and wraps
        while (exp_lines < 70) begin
            pick_piece(0, cols_n);
            place_piece();
        end

        run_timer(first_run);
        repeat (idle_time) @(posedge clk);
        request_check();
        run_timer(second_run);

        // new game over a busy board and a nonzero timer
        pick_piece(0, cols_n - 1);
        place_piece();
        @(posedge clk);
        game_start <= 1'b1;
        @(posedge clk);
        game_start <= 1'b0;
        clear_model();
        request_check();

        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* design/tetris_board_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tetris_board_top #(
    parameter int ticks_per_ms = tetris_pkg::TICKS_PER_MS_DEFAULT
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     game_start,
    input  logic                     lock,
    input  tetris_pkg::row_idx_t     lock_rows [tetris_pkg::PIECE_CELLS],
    input  tetris_pkg::col_idx_t     lock_cols [tetris_pkg::PIECE_CELLS],
    input  tetris_pkg::tile_type_t   lock_type,
    input  logic                     timer_running,
    output tetris_pkg::tile_type_t   board [tetris_pkg::PLAYFIELD_ROWS]
                                           [tetris_pkg::PLAYFIELD_COLS],
    output tetris_pkg::lines_count_t lines_cleared,
    output logic                     board_settled,
    output tetris_pkg::digit_t       time_digits [tetris_pkg::TIME_DIGITS]
);

    logic [tetris_pkg::PLAYFIELD_COLS-1:0] write_masks [tetris_pkg::PLAYFIELD_ROWS];
    tetris_pkg::tile_type_t                write_type;
    tetris_pkg::tile_type_t                above_cells [tetris_pkg::PLAYFIELD_ROWS]
                                                       [tetris_pkg::PLAYFIELD_COLS];
    logic                                  below_empty [tetris_pkg::PLAYFIELD_ROWS];
    logic                                  row_full    [tetris_pkg::PLAYFIELD_ROWS];
    logic                                  row_empty   [tetris_pkg::PLAYFIELD_ROWS];

    lock_writer u_lock_writer (
        .lock        (lock),
        .lock_rows   (lock_rows),
        .lock_cols   (lock_cols),
        .lock_type   (lock_type),
        .write_masks (write_masks),
        .write_type  (write_type)
    );

    for (genvar g = 0; g < tetris_pkg::PLAYFIELD_ROWS; g++) begin : g_row
        // nothing above the top row
        if (g == 0) begin : g_top
            assign above_cells[g] = '{default: tetris_pkg::BLANK};
        end else begin : g_inner
            assign above_cells[g] = board[g-1];
        end

        // floor under the bottom row is never empty
        if (g == tetris_pkg::PLAYFIELD_ROWS - 1) begin : g_floor
            assign below_empty[g] = 1'b0;
        end else begin : g_link
            assign below_empty[g] = row_empty[g+1];
        end

        playfield_row #(
            .is_top_row (g == 0)
        ) u_row (
            .clk         (clk),
            .reset       (reset),
            .game_start  (game_start),
            .write_mask  (write_masks[g]),
            .write_type  (write_type),
            .row_above   (above_cells[g]),
            .below_empty (below_empty[g]),
            .cells       (board[g]),
            .row_full    (row_full[g]),
            .row_empty   (row_empty[g])
        );
    end

    line_clear_counter u_line_clear_counter (
        .clk           (clk),
        .reset         (reset),
        .game_start    (game_start),
        .row_full      (row_full),
        .row_empty     (row_empty),
        .lines_cleared (lines_cleared),
        .board_settled (board_settled)
    );

    sprint_timer #(
        .ticks_per_ms (ticks_per_ms)
    ) u_sprint_timer (
        .clk           (clk),
        .reset         (reset),
        .game_start    (game_start),
        .timer_running (timer_running),
        .time_digits   (time_digits)
    );

endmodule

`default_nettype wire

/* design/sprint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sprint_timer #(
    parameter int ticks_per_ms = tetris_pkg::TICKS_PER_MS_DEFAULT
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               game_start,
    input  logic               timer_running,
    output tetris_pkg::digit_t time_digits [tetris_pkg::TIME_DIGITS]
);

    localparam int div_width = $clog2(ticks_per_ms + 1);

    logic [div_width-1:0]             tick_count;
    logic                             ms_tick;
    logic [tetris_pkg::TIME_DIGITS:0] carry;

    // last running cycle of each millisecond
    assign ms_tick = timer_running &&
                     (tick_count == div_width'(ticks_per_ms - 1));

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            tick_count <= '0;
        end else if (timer_running) begin
            tick_count <= ms_tick ? '0 : tick_count + 1'b1;
        end
    end

    assign carry[0] = ms_tick;

    // ms stage first and hours last
    for (genvar g = 0; g < tetris_pkg::TIME_DIGITS; g++) begin : g_digit
        time_digit #(
            .limit (tetris_pkg::DIGIT_LIMITS[g])
        ) u_digit (
            .clk        (clk),
            .reset      (reset),
            .game_start (game_start),
            .carry_in   (carry[g]),
            .value      (time_digits[g]),
            .carry_out  (carry[g+1])
        );
    end

endmodule

`default_nettype wire

/* design/time_digit.sv */
`timescale 1ns/1ps
`default_nettype none

module time_digit #(
    parameter tetris_pkg::digit_t limit = 6'd9
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               game_start,
    input  logic               carry_in,
    output tetris_pkg::digit_t value,
    output logic               carry_out
);

    logic at_limit;

    assign at_limit  = (value == limit);
    // carry leaves in the same cycle the digit wraps
    assign carry_out = carry_in && at_limit;

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            value <= '0;
        end else if (carry_in) begin
            value <= at_limit ? '0 : value + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* design/line_clear_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module line_clear_counter (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     game_start,
    input  logic                     row_full  [tetris_pkg::PLAYFIELD_ROWS],
    input  logic                     row_empty [tetris_pkg::PLAYFIELD_ROWS],
    output tetris_pkg::lines_count_t lines_cleared,
    output logic                     board_settled
);

    tetris_pkg::lines_count_t full_count;
    logic                     any_full;
    logic                     seen_filled;
    logic                     gap_found;

    // number of rows clearing this cycle
    always_comb begin
        full_count = '0;
        any_full   = 1'b0;
        for (int i = 0; i < tetris_pkg::PLAYFIELD_ROWS; i++) begin
            full_count = full_count + tetris_pkg::lines_count_t'(row_full[i]);
            any_full   = any_full | row_full[i];
        end
    end

    // top-down scan for an empty row under a filled one
    always_comb begin
        seen_filled = 1'b0;
        gap_found   = 1'b0;
        for (int i = 0; i < tetris_pkg::PLAYFIELD_ROWS; i++) begin
            if (!row_empty[i]) begin
                seen_filled = 1'b1;
            end else if (seen_filled) begin
                gap_found = 1'b1;
            end
        end
    end

    assign board_settled = !any_full && !gap_found;

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            lines_cleared <= '0;
        end else if (any_full) begin
            lines_cleared <= lines_cleared + full_count;
        end
    end

endmodule

`default_nettype wire

/* design/playfield_row.sv */
`timescale 1ns/1ps
`default_nettype none

module playfield_row #(
    parameter bit is_top_row = 1'b0
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 game_start,
    input  logic [tetris_pkg::PLAYFIELD_COLS-1:0] write_mask,
    input  tetris_pkg::tile_type_t               write_type,
    input  tetris_pkg::tile_type_t               row_above [tetris_pkg::PLAYFIELD_COLS],
    input  logic                                 below_empty,
    output tetris_pkg::tile_type_t               cells [tetris_pkg::PLAYFIELD_COLS],
    output logic                                 row_full,
    output logic                                 row_empty
);

    // full and empty flags straight from the stored tiles
    always_comb begin
        row_full  = 1'b1;
        row_empty = 1'b1;
        for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
            if (cells[c] == tetris_pkg::BLANK) begin
                row_full = 1'b0;
            end else begin
                row_empty = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || game_start) begin
            cells <= '{default: tetris_pkg::BLANK};
        end else begin
            for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                if (write_mask[c]) begin
                    // lock write wins over clear and collapse
                    cells[c] <= write_type;
                end else if (row_full) begin
                    cells[c] <= tetris_pkg::BLANK;
                end else if (row_empty && !is_top_row) begin
                    // pull the row above down into the gap
                    cells[c] <= row_above[c];
                end else if (below_empty) begin
                    // contents moved down a row
                    cells[c] <= tetris_pkg::BLANK;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* design/lock_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module lock_writer (
    input  logic                                     lock,
    input  tetris_pkg::row_idx_t                     lock_rows [tetris_pkg::PIECE_CELLS],
    input  tetris_pkg::col_idx_t                     lock_cols [tetris_pkg::PIECE_CELLS],
    input  tetris_pkg::tile_type_t                   lock_type,
    output logic [tetris_pkg::PLAYFIELD_COLS-1:0]    write_masks [tetris_pkg::PLAYFIELD_ROWS],
    output tetris_pkg::tile_type_t                   write_type
);

    // mask bit set for each board cell a piece cell lands on
    always_comb begin
        for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
            write_masks[r] = '0;
        end
        if (lock) begin
            for (int r = 0; r < tetris_pkg::PLAYFIELD_ROWS; r++) begin
                for (int c = 0; c < tetris_pkg::PLAYFIELD_COLS; c++) begin
                    for (int k = 0; k < tetris_pkg::PIECE_CELLS; k++) begin
                        if (lock_rows[k] == tetris_pkg::row_idx_t'(r) &&
                            lock_cols[k] == tetris_pkg::col_idx_t'(c)) begin
                            write_masks[r][c] = 1'b1;
                        end
                    end
                end
            end
        end
    end

    // type only lands where a mask bit is set
    assign write_type = lock_type;

endmodule

`default_nettype wire

/* design/tetris_pkg.sv */
`default_nettype none

package tetris_pkg;

    // board geometry with row 0 at the top
    localparam int PLAYFIELD_ROWS = 20;
    localparam int PLAYFIELD_COLS = 10;
    localparam int PIECE_CELLS    = 4;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;

    // tile encoding of a locked cell
    typedef enum logic [2:0] {
        BLANK = 3'd0,
        I     = 3'd1,
        O     = 3'd2,
        T     = 3'd3,
        S     = 3'd4,
        Z     = 3'd5,
        J     = 3'd6,
        L     = 3'd7
    } tile_type_t;

    // wraps past 63
    typedef logic [5:0] lines_count_t;

    // sprint timer stages from milliseconds up
    localparam int TIME_DIGITS = 6;

    typedef logic [5:0] digit_t;

    // ms, cs, ds, seconds, minutes, hours
    localparam digit_t DIGIT_LIMITS [TIME_DIGITS] = '{
        6'd9,
        6'd9,
        6'd9,
        6'd59,
        6'd59,
        6'd31
    };

    // 50 MHz board clock
    localparam int TICKS_PER_MS_DEFAULT = 50_000;

endpackage

`default_nettype wire
